//--- Makefile
TOP := tb_stm_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

//--- common/stm_defs.svh
`ifndef STM_DEFS_SVH
`define STM_DEFS_SVH

// Transducers streamed per pattern
`define STM_DEPTH 249

// Patterns held in the gain memory
`define STM_PATTERN_NUM 8

// 128-bit lines reserved for each pattern
`define STM_LINES_PER_PATTERN 32

// Lane select inside a line, eight 16-bit lanes
`define STM_LANE_W 3

// Line address on the read side
`define STM_LINE_ADDR_W 8

// Host write address is {line, lane}
`define STM_WR_ADDR_W 11

`define STM_IDX_W 16
`define STM_INTERVAL_W 16

`endif

//--- common/stm_pkg.sv
`include "stm_defs.svh"

package stm_pkg;

  typedef logic [7:0] phase_t;
  typedef logic [7:0] intensity_t;

  // One transducer as stored in memory
  typedef struct packed {
    intensity_t intensity;  // High byte
    phase_t     phase;      // Low byte
  } gain_lane_t;

  // Lane 0 sits in bits 15:0
  typedef gain_lane_t [(1 << `STM_LANE_W)-1:0] gain_line_t;

  // Gain operator FSM
  typedef enum logic [1:0] {
    op_waiting,
    op_bram_wait_0,
    op_bram_wait_1,
    op_run
  } op_state_t;

endpackage

//--- hw/stm_top.sv
`include "stm_defs.svh"

module stm_top (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        stm_en,
  input  logic [`STM_IDX_W-1:0]       cycle,
  input  logic [`STM_INTERVAL_W-1:0]  interval,
  input  logic                        wr_en,
  input  logic [`STM_WR_ADDR_W-1:0]   wr_addr,
  input  logic [15:0]                 wr_data,
  output stm_pkg::intensity_t         intensity,
  output stm_pkg::phase_t             phase,
  output logic                        dout_valid,
  output logic [`STM_IDX_W-1:0]       idx
);

  import stm_pkg::*;

  logic                        update;
  logic [`STM_LINE_ADDR_W-1:0] rd_addr;
  gain_line_t                  rd_data;

  stm_sequencer u_sequencer (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .stm_en   (stm_en),
    .cycle    (cycle),
    .interval (interval),
    .update   (update),
    .idx      (idx)
  );

  stm_gain_ram u_gain_ram (
    .CLK     (CLK),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // Operator reads the line addressed by the index sampled on update
  stm_gain_operator #(
    .DEPTH (`STM_DEPTH)
  ) u_gain_operator (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .update     (update),
    .idx        (idx),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .intensity  (intensity),
    .phase      (phase),
    .dout_valid (dout_valid)
  );

endmodule

//--- src.f
+incdir+common
common/stm_pkg.sv
stm/stm_gain_ram.sv
stm/stm_gain_operator.sv
stm/stm_sequencer.sv
hw/stm_top.sv
testbench/tb_clock_gen.sv
testbench/tb_stm_asserts.sv
testbench/tb_stm_top.sv

//--- stm/stm_gain_operator.sv
`include "stm_defs.svh"

module stm_gain_operator #(
  parameter int DEPTH = `STM_DEPTH
) (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  logic                        update,
  input  logic [`STM_IDX_W-1:0]       idx,
  output logic [`STM_LINE_ADDR_W-1:0] rd_addr,
  input  stm_pkg::gain_line_t         rd_data,
  output stm_pkg::intensity_t         intensity,
  output stm_pkg::phase_t             phase,
  output logic                        dout_valid
);

  import stm_pkg::*;

  // Offset covers two patterns, base picks the pattern pair
  localparam int OFFSET_W = $clog2(`STM_LINES_PER_PATTERN) + 1;
  localparam int BASE_W   = `STM_LINE_ADDR_W - OFFSET_W;
  localparam int CNT_W    = $clog2(DEPTH + 1);

  // Next line requested here so it lands on lane 0
  localparam logic [`STM_LANE_W-1:0] ADVANCE_LANE = 5;

  op_state_t              state;
  logic [BASE_W-1:0]      addr_base;
  logic [OFFSET_W-1:0]    addr_offset;
  logic [`STM_LANE_W-1:0] lane;   // Lane within the current line
  logic [CNT_W-1:0]       cnt;    // Pairs sent so far
  logic                   burst_done;

  assign rd_addr    = {addr_base, addr_offset};
  assign burst_done = (cnt == CNT_W'(DEPTH));

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state       <= op_waiting;
      dout_valid  <= 1'b0;
      addr_base   <= '0;
      addr_offset <= '0;
      lane        <= '0;
      cnt         <= '0;
    end else begin
      case (state)
        op_waiting: begin
          if (update) begin
            // Pattern idx starts at line idx * 32
            addr_base   <= idx[BASE_W:1];
            addr_offset <= idx[0] ? OFFSET_W'(`STM_LINES_PER_PATTERN) : '0;
            state       <= op_bram_wait_0;
          end
        end
        op_bram_wait_0: begin
          state <= op_bram_wait_1;
        end
        op_bram_wait_1: begin
          lane  <= '0;
          cnt   <= '0;
          state <= op_run;  // First line is on rd_data next cycle
        end
        op_run: begin
          if (burst_done) begin
            dout_valid <= 1'b0;
            state      <= op_waiting;
          end else begin
            dout_valid <= 1'b1;
            lane       <= lane + 1'b1;  // Wraps after lane 7
            cnt        <= cnt + 1'b1;
            if (lane == ADVANCE_LANE) begin
              addr_offset <= addr_offset + 1'b1;
            end
          end
        end
        default: begin
          state <= op_waiting;
        end
      endcase
    end
  end

  // Output pair, holds its last value between bursts
  always_ff @(posedge CLK) begin
    if (state == op_run && !burst_done) begin
      phase     <= rd_data[lane].phase;
      intensity <= rd_data[lane].intensity;
    end
  end

endmodule

//--- stm/stm_gain_ram.sv
`include "stm_defs.svh"

module stm_gain_ram (
  input  logic                        CLK,
  input  logic                        wr_en,
  input  logic [`STM_WR_ADDR_W-1:0]   wr_addr,
  input  logic [15:0]                 wr_data,
  input  logic [`STM_LINE_ADDR_W-1:0] rd_addr,
  output stm_pkg::gain_line_t         rd_data
);

  import stm_pkg::*;

  localparam int LINE_NUM = `STM_PATTERN_NUM * `STM_LINES_PER_PATTERN;

  gain_line_t mem [LINE_NUM];

  logic [`STM_LINE_ADDR_W-1:0] wr_line;
  logic [`STM_LANE_W-1:0]      wr_lane;
  logic [`STM_LINE_ADDR_W-1:0] rd_addr_q;

  // Host address splits into line and lane
  assign wr_line = wr_addr[`STM_WR_ADDR_W-1:`STM_LANE_W];
  assign wr_lane = wr_addr[`STM_LANE_W-1:0];

  // Single lane write, other lanes of the line untouched
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_line][wr_lane] <= gain_lane_t'(wr_data);
    end
  end

  // Registered address then registered output
  always_ff @(posedge CLK) begin
    rd_addr_q <= rd_addr;
    rd_data   <= mem[rd_addr_q];
  end

endmodule

//--- stm/stm_sequencer.sv
`include "stm_defs.svh"

module stm_sequencer (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic                       stm_en,
  input  logic [`STM_IDX_W-1:0]      cycle,
  input  logic [`STM_INTERVAL_W-1:0] interval,
  output logic                       update,
  output logic [`STM_IDX_W-1:0]      idx
);

  logic [`STM_INTERVAL_W-1:0] intv_cnt;
  logic                       interval_hit;
  logic                       idx_wrap;

  // Widened compares so interval or cycle of 0 cannot underflow
  assign interval_hit = ({1'b0, intv_cnt} + 1'b1) >= {1'b0, interval};
  assign idx_wrap     = ({1'b0, idx} + 1'b1) >= {1'b0, cycle};

  // Interval counter and update pulse
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      intv_cnt <= '0;
      update   <= 1'b0;
    end else if (!stm_en) begin
      intv_cnt <= '0;
      update   <= 1'b0;
    end else if (interval_hit) begin
      intv_cnt <= '0;
      update   <= 1'b1;
    end else begin
      intv_cnt <= intv_cnt + 1'b1;
      update   <= 1'b0;
    end
  end

  // Pattern index moves on once the pulse has been seen
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      idx <= '0;
    end else if (!stm_en) begin
      idx <= '0;
    end else if (update) begin
      idx <= idx_wrap ? '0 : idx + 1'b1;
    end
  end

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic CLK,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Low across the first two rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    #(2 * PERIOD) rst_n = 1'b1;
  end

endmodule

//--- testbench/tb_stm_asserts.sv
`include "stm_defs.svh"

module tb_stm_asserts #(
  parameter int DEPTH = `STM_DEPTH
) (
  input logic               CLK,
  input logic               rst_n,
  input logic               update,
  input logic               dout_valid,
  input stm_pkg::op_state_t state
);
  timeunit 1ns;
  timeprecision 1ps;

  import stm_pkg::*;

  logic       accepted;
  logic       dropped;
  logic [3:0] accept_hist;  // One bit per cycle back
  logic [3:0] drop_hist;    // Updates that arrived during run
  int         valid_run;    // Cycles in a row with dout_valid high

  assign accepted = (state == op_waiting) && update;
  assign dropped  = (state == op_run) && update;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      accept_hist <= '0;
      drop_hist   <= '0;
      valid_run   <= 0;
    end else begin
      accept_hist <= {accept_hist[2:0], accepted};
      drop_hist   <= {drop_hist[2:0], dropped};
      valid_run   <= dout_valid ? valid_run + 1 : 0;
    end
  end

  // Two memory waits and the run entry come before pair 0
  a_valid_after_update: assert property (
    @(posedge CLK) disable iff (!rst_n) accept_hist[3] |-> $rose(dout_valid)
  ) else $error("dout_valid did not rise four cycles after an accepted update");

  a_burst_length: assert property (
    @(posedge CLK) disable iff (!rst_n) valid_run <= DEPTH
  ) else $error("dout_valid stayed high longer than one burst");

  // A dropped update must not start a burst of its own
  a_no_update_in_run: assert property (
    @(posedge CLK) disable iff (!rst_n) drop_hist[3] |-> !$rose(dout_valid)
  ) else $error("update was taken while the operator was running");

endmodule

bind stm_gain_operator tb_stm_asserts #(
  .DEPTH (DEPTH)
) u_asserts (
  .CLK        (CLK),
  .rst_n      (rst_n),
  .update     (update),
  .dout_valid (dout_valid),
  .state      (state)
);

//--- testbench/tb_stm_top.sv
`include "stm_defs.svh"

module tb_stm_top;
  timeunit 1ns;
  timeprecision 1ps;

  import stm_pkg::*;

  localparam int DEPTH    = `STM_DEPTH;
  localparam int LANES    = 1 << `STM_LANE_W;
  localparam int WR_WORDS = 1 << `STM_WR_ADDR_W;

  logic                       CLK;
  logic                       rst_n;
  logic                       stm_en;
  logic [`STM_IDX_W-1:0]      cycle;
  logic [`STM_INTERVAL_W-1:0] interval;
  logic                       wr_en;
  logic [`STM_WR_ADDR_W-1:0]  wr_addr;
  logic [15:0]                wr_data;
  intensity_t                 intensity;
  phase_t                     phase;
  logic                       dout_valid;
  logic [`STM_IDX_W-1:0]      idx;

  logic [15:0] model_mem [WR_WORDS];  // Copy of every host write
  int seed        = 5176;
  int err_cnt     = 0;
  int timeout_cnt = 0;

  bit                    in_burst = 1'b0;
  int                    burst_len;
  int                    burst_cnt = 0;
  int                    cur_pattern;
  logic [`STM_IDX_W-1:0] start_idx_q [$];  // idx seen at each burst start

  tb_clock_gen u_clock_gen (.CLK(CLK), .rst_n(rst_n));

  stm_top uut (
    .CLK (CLK), .rst_n (rst_n), .stm_en (stm_en), .cycle (cycle), .interval (interval),
    .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data), .intensity (intensity),
    .phase (phase), .dout_valid (dout_valid), .idx (idx)
  );

  // Pair k is lane k mod 8 of line idx * 32 + k div 8, returned as {intensity, phase}
  function automatic logic [15:0] expected_pair(int pattern, int k);
    int line;
    line = pattern * `STM_LINES_PER_PATTERN + k / LANES;
    return model_mem[line * LANES + k % LANES];
  endfunction

  // The sequencer has already stepped past the pattern being streamed
  function automatic int pattern_of(logic [`STM_IDX_W-1:0] start);
    return (int'(start) + int'(cycle) - 1) % int'(cycle);
  endfunction

  task automatic check_phase(string name, phase_t exp, phase_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s expected 0x%02h actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic check_intensity(string name, intensity_t exp, intensity_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s expected 0x%02h actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic check_idx(string name, logic [`STM_IDX_W-1:0] exp, logic [`STM_IDX_W-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      err_cnt++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Monitor, compares every pair of a burst and its length
  always @(negedge CLK) begin : monitor
    logic [15:0] exp_word;
    if (!rst_n) begin
      in_burst = 1'b0;
    end else if (dout_valid) begin
      if (!in_burst) begin
        in_burst    = 1'b1;
        burst_len   = 0;
        cur_pattern = pattern_of(idx);
        start_idx_q.push_back(idx);
      end
      if (burst_len < DEPTH) begin
        exp_word = expected_pair(cur_pattern, burst_len);
        check_phase($sformatf("pattern %0d pair %0d phase", cur_pattern, burst_len),
                    exp_word[7:0], phase);
        check_intensity($sformatf("pattern %0d pair %0d intensity", cur_pattern, burst_len),
                        exp_word[15:8], intensity);
      end
      burst_len++;
    end else if (in_burst) begin
      in_burst = 1'b0;
      check_count($sformatf("burst %0d length", burst_cnt), DEPTH, burst_len);
      burst_cnt++;
    end
  end

  task automatic wait_reset_done();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 10) begin
      @(posedge CLK);
      n++;
    end
    if (rst_n !== 1'b1) begin
      timeout_cnt++;
      $display("Timeout waiting for reset to be released");
    end
  endtask

  task automatic wait_bursts(int target, int limit, string what);
    int n;
    n = 0;
    while (burst_cnt < target && n < limit) begin
      @(posedge CLK);
      n++;
    end
    if (burst_cnt < target) begin
      timeout_cnt++;
      $display("Timeout waiting for %s, saw %0d of %0d bursts", what, burst_cnt, target);
    end
  endtask

  task automatic wait_burst_start(int limit);
    int n;
    n = 0;
    while (!in_burst && n < limit) begin
      @(posedge CLK);
      n++;
    end
    if (!in_burst) begin
      timeout_cnt++;
      $display("Timeout waiting for a burst to start");
    end
  endtask

  // Idle means eight quiet cycles, longer than the update to data delay
  task automatic wait_idle(int limit);
    int n;
    int quiet;
    n = 0;
    quiet = 0;
    while (quiet < 8 && n < limit) begin
      @(posedge CLK);
      n++;
      quiet = in_burst ? 0 : quiet + 1;
    end
    if (quiet < 8) begin
      timeout_cnt++;
      $display("Timeout waiting for the gain stream to go idle");
    end
  endtask

  task automatic load_patterns();
    for (int a = 0; a < WR_WORDS; a++) begin
      @(negedge CLK);
      wr_en        = 1'b1;
      wr_addr      = a[`STM_WR_ADDR_W-1:0];
      wr_data      = 16'($random(seed));
      model_mem[a] = wr_data;
    end
    @(negedge CLK);
    wr_en = 1'b0;
  endtask

  task automatic start_sequencer(int cyc, int intv);
    @(negedge CLK);
    cycle    = cyc[`STM_IDX_W-1:0];
    interval = intv[`STM_INTERVAL_W-1:0];
    stm_en   = 1'b1;
  endtask

  task automatic stop_sequencer();
    @(negedge CLK);
    stm_en = 1'b0;
  endtask

  task automatic check_quiet(string name, int cycles);
    repeat (cycles) begin
      @(negedge CLK);
      check_valid({name, " dout_valid"}, 1'b0, dout_valid);
      check_idx({name, " idx"}, '0, idx);
    end
  endtask

  // Burst n carries pattern (n * step) mod cyc, idx one further on
  task automatic check_sequence(string name, int base, int cyc, int step, int count);
    logic [`STM_IDX_W-1:0] exp_idx;
    for (int n = 0; n < count; n++) begin
      exp_idx = ((n * step) % cyc + 1) % cyc;
      if (base + n >= start_idx_q.size()) begin
        err_cnt++;
        $display("%s burst %0d never appeared", name, n);
      end else begin
        check_idx($sformatf("%s burst %0d idx", name, n), exp_idx, start_idx_q[base + n]);
      end
    end
  endtask

  initial begin : stimulus
    int base;
    stm_en   = 1'b0;
    cycle    = 1;
    interval = 260;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_data  = '0;
    wait_reset_done();

    check_quiet("after reset", 20);
    load_patterns();
    check_quiet("after load", 4);

    base = burst_cnt;
    start_sequencer(1, 260);
    wait_bursts(base + 3, 1500, "three bursts of pattern 0");
    stop_sequencer();
    wait_idle(400);
    check_sequence("cycle 1", base, 1, 1, 3);

    base = burst_cnt;
    start_sequencer(5, 260);
    wait_bursts(base + 6, 2400, "six bursts over five patterns");
    stop_sequencer();
    wait_idle(400);
    check_sequence("cycle 5", base, 5, 1, 6);

    // Every second update lands inside a burst
    base = burst_cnt;
    start_sequencer(5, 200);
    wait_bursts(base + 4, 2200, "four bursts at interval 200");
    check_sequence("interval 200", base, 5, 2, 4);

    wait_burst_start(450);
    stop_sequencer();
    @(negedge CLK);
    check_idx("idx after stop", '0, idx);
    wait_idle(400);
    base = burst_cnt;
    check_quiet("after stop", 600);
    check_count("bursts after stop", base, burst_cnt);

    $display("Errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
